// File: build.f
cpu_pkg.sv
cpu_ctrl.sv
inst_fetch.sv
exec_unit.sv
reg_file.sv
data_bridge.sv
cpu_top.sv
tb_cpu.sv

// File: cpu_ctrl.sv
module cpu_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic group_done,
    input  logic group_hit,
    input  logic mem_done,
    input  logic is_mem_op,
    output logic fetch_start,
    output logic mem_start,
    output logic exec_en,
    output logic wb_load,
    output logic io_stall
);

    typedef enum logic [2:0] {
        IDLE,
        FETCH_GROUP,
        READ_BUF,
        EX,
        MEM,
        RETIRE
    } state_t;

    state_t state;
    state_t next_state;
    logic   from_mem;

    // ============================================================
    // instruction cycle FSM
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:        next_state = FETCH_GROUP;
            FETCH_GROUP: if (group_done) next_state = READ_BUF;
            // buffer read takes this cycle
            READ_BUF:    next_state = EX;
            EX:          next_state = is_mem_op ? MEM : RETIRE;
            MEM:         if (mem_done) next_state = RETIRE;
            RETIRE:      next_state = group_hit ? READ_BUF : FETCH_GROUP;
            default:     next_state = IDLE;
        endcase
    end

    // start pulses in the first cycle of FETCH_GROUP and MEM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_start <= 1'b0;
            mem_start   <= 1'b0;
            from_mem    <= 1'b0;
            io_stall    <= 1'b1;
        end else begin
            fetch_start <= (next_state == FETCH_GROUP) && (state != FETCH_GROUP);
            mem_start   <= (next_state == MEM) && (state != MEM);
            from_mem    <= (state == MEM);
            // one low cycle right after each retire
            io_stall    <= (state != RETIRE);
        end
    end

    assign exec_en = (state == EX);

    // retire after a memory access, the bridge data goes back to rt
    assign wb_load = (state == RETIRE) && from_mem;

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

    // ============================================================
    // data types
    // ============================================================

    // register and memory data word
    typedef logic signed [15:0] word_t;

    // register number
    typedef logic [3:0] reg_idx_t;

    // instruction word index
    typedef logic [10:0] pc_t;

    // dram byte address
    typedef logic [31:0] bus_addr_t;

    // ============================================================
    // opcodes, bits 15:13 of the instruction
    // ============================================================

    // func 1 add, func 0 sub
    localparam logic [2:0] OP_ADDSUB = 3'b000;
    // func 1 slt, func 0 mul
    localparam logic [2:0] OP_SLTMUL = 3'b001;
    localparam logic [2:0] OP_STORE  = 3'b010;
    localparam logic [2:0] OP_LOAD   = 3'b011;
    localparam logic [2:0] OP_JUMP   = 3'b100;
    localparam logic [2:0] OP_BEQ    = 3'b101;

    // ============================================================
    // address map
    // ============================================================

    // size of the instruction word space
    localparam int PC_WORDS = 2048;

    // byte address of word index 0, word w sits at base + 2*w
    localparam bus_addr_t DRAM_BASE = 32'h0000_1000;

endpackage

// File: cpu_top.sv
module cpu_top #(
    parameter int                 GROUP_WORDS = 128,
    parameter cpu_pkg::bus_addr_t DRAM_BASE   = cpu_pkg::DRAM_BASE
) (
    input  logic               clk,
    input  logic               rst_n,
    // instruction read port
    output logic               ar_valid,
    output cpu_pkg::bus_addr_t ar_addr,
    input  logic               ar_ready,
    input  logic               r_valid,
    input  cpu_pkg::word_t     r_data,
    input  logic               r_last,
    output logic               r_ready,
    // data read port
    output logic               dr_ar_valid,
    output cpu_pkg::bus_addr_t dr_ar_addr,
    input  logic               dr_ar_ready,
    input  logic               dr_r_valid,
    input  cpu_pkg::word_t     dr_r_data,
    output logic               dr_r_ready,
    // data write port
    output logic               aw_valid,
    output cpu_pkg::bus_addr_t aw_addr,
    input  logic               aw_ready,
    output logic               w_valid,
    output cpu_pkg::word_t     w_data,
    input  logic               w_ready,
    input  logic               b_valid,
    output logic               b_ready,
    output logic               io_stall
);
    import cpu_pkg::*;

    // controller handshakes
    logic      fetch_start;
    logic      mem_start;
    logic      exec_en;
    logic      wb_load;
    logic      group_done;
    logic      group_hit;
    logic      mem_done;

    // datapath
    pc_t       pc;
    word_t     inst_word;
    reg_idx_t  rs_idx;
    reg_idx_t  rt_idx;
    reg_idx_t  wr_idx;
    word_t     rs_val;
    word_t     rt_val;
    word_t     alu_result;
    word_t     load_data;
    logic      wr_alu;
    logic      is_mem_op;
    logic      is_load;
    bus_addr_t mem_addr;

    cpu_ctrl u_ctrl (.*);

    inst_fetch #(
        .GROUP_WORDS (GROUP_WORDS),
        .DRAM_BASE   (DRAM_BASE)
    ) u_fetch (.*);

    exec_unit #(
        .DRAM_BASE (DRAM_BASE)
    ) u_exec (.*);

    reg_file u_regs (
        .we_alu (wr_alu),
        .*
    );

    data_bridge u_data (
        .store_data (rt_val),
        .*
    );

endmodule

// File: data_bridge.sv
module data_bridge (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem_start,
    input  logic               is_load,
    input  cpu_pkg::bus_addr_t mem_addr,
    input  cpu_pkg::word_t     store_data,
    output logic               mem_done,
    output cpu_pkg::word_t     load_data,
    // read port
    output logic               dr_ar_valid,
    output cpu_pkg::bus_addr_t dr_ar_addr,
    input  logic               dr_ar_ready,
    input  logic               dr_r_valid,
    input  cpu_pkg::word_t     dr_r_data,
    output logic               dr_r_ready,
    // write port
    output logic               aw_valid,
    output cpu_pkg::bus_addr_t aw_addr,
    input  logic               aw_ready,
    output logic               w_valid,
    output cpu_pkg::word_t     w_data,
    input  logic               w_ready,
    input  logic               b_valid,
    output logic               b_ready
);
    import cpu_pkg::*;

    bus_addr_t addr_q;
    word_t     data_q;
    logic      rd_beat;

    assign rd_beat  = dr_r_valid && dr_r_ready;
    assign mem_done = rd_beat || (b_valid && b_ready);

    // ============================================================
    // request channels
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dr_ar_valid <= 1'b0;
            aw_valid    <= 1'b0;
            w_valid     <= 1'b0;
            dr_r_ready  <= 1'b0;
            b_ready     <= 1'b0;
        end else begin
            dr_r_ready <= 1'b1;
            b_ready    <= 1'b1;
            if (mem_start && is_load) begin
                dr_ar_valid <= 1'b1;
            end else if (dr_ar_valid && dr_ar_ready) begin
                dr_ar_valid <= 1'b0;
            end
            if (mem_start && !is_load) begin
                aw_valid <= 1'b1;
            end else if (aw_valid && aw_ready) begin
                aw_valid <= 1'b0;
            end
            // data beat follows the address transfer
            if (aw_valid && aw_ready) begin
                w_valid <= 1'b1;
            end else if (w_valid && w_ready) begin
                w_valid <= 1'b0;
            end
        end
    end

    // one data register for both directions
    // after a store it still holds rt, so the writeback leaves rt unchanged
    always_ff @(posedge clk) begin
        if (mem_start) begin
            addr_q <= mem_addr;
            data_q <= store_data;
        end else if (rd_beat) begin
            data_q <= dr_r_data;
        end
    end

    assign dr_ar_addr = addr_q;
    assign aw_addr    = addr_q;
    assign w_data     = data_q;
    assign load_data  = data_q;

endmodule

// File: exec_unit.sv
module exec_unit #(
    parameter cpu_pkg::bus_addr_t DRAM_BASE = cpu_pkg::DRAM_BASE
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               exec_en,
    input  cpu_pkg::word_t     inst_word,
    input  cpu_pkg::word_t     rs_val,
    input  cpu_pkg::word_t     rt_val,
    output cpu_pkg::reg_idx_t  rs_idx,
    output cpu_pkg::reg_idx_t  rt_idx,
    output cpu_pkg::reg_idx_t  wr_idx,
    output cpu_pkg::word_t     alu_result,
    output logic               wr_alu,
    output logic               is_mem_op,
    output logic               is_load,
    output cpu_pkg::bus_addr_t mem_addr,
    output cpu_pkg::pc_t       pc
);
    import cpu_pkg::*;

    word_t             inst_q;
    word_t             cur;
    logic [2:0]        opcode;
    logic              func;
    logic signed [4:0] imm;
    word_t             data_idx;
    logic              r_type;
    logic              beq_taken;

    // decode straight from the buffer in EX, from the latch afterwards
    assign cur    = exec_en ? inst_word : inst_q;
    assign opcode = cur[15:13];
    assign rs_idx = cur[12:9];
    assign rt_idx = cur[8:5];
    assign func   = cur[0];
    assign imm    = cur[4:0];

    assign r_type    = (opcode == OP_ADDSUB) || (opcode == OP_SLTMUL);
    assign is_load   = (opcode == OP_LOAD);
    assign is_mem_op = (opcode == OP_LOAD) || (opcode == OP_STORE);
    assign wr_idx    = r_type ? reg_idx_t'(cur[4:1]) : rt_idx;
    assign wr_alu    = exec_en && r_type;
    assign beq_taken = (opcode == OP_BEQ) && (rs_val == rt_val);

    // (rs + imm) * 2 + base
    assign data_idx = rs_val + word_t'(imm);
    assign mem_addr = DRAM_BASE + (bus_addr_t'(data_idx) << 1);

    always_comb begin
        case (opcode)
            OP_ADDSUB: alu_result = func ? rs_val + rt_val : rs_val - rt_val;
            OP_SLTMUL: begin
                if (func) begin
                    alu_result = (rs_val < rt_val) ? word_t'(1) : word_t'(0);
                end else begin
                    // low half of the product
                    alu_result = rs_val * rt_val;
                end
            end
            default:   alu_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_q <= '0;
            pc     <= '0;
        end else if (exec_en) begin
            inst_q <= inst_word;
            if (opcode == OP_JUMP) begin
                pc <= cur[11:1];
            end else if (beq_taken) begin
                pc <= pc + 11'd1 + pc_t'(imm);
            end else begin
                pc <= pc + 11'd1;
            end
        end
    end

endmodule

// File: inst_fetch.sv
module inst_fetch #(
    parameter int                 GROUP_WORDS = 128,
    parameter cpu_pkg::bus_addr_t DRAM_BASE   = cpu_pkg::DRAM_BASE
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fetch_start,
    input  cpu_pkg::pc_t       pc,
    output logic               ar_valid,
    output cpu_pkg::bus_addr_t ar_addr,
    input  logic               ar_ready,
    input  logic               r_valid,
    input  cpu_pkg::word_t     r_data,
    input  logic               r_last,
    output logic               r_ready,
    output logic               group_done,
    output logic               group_hit,
    output cpu_pkg::word_t     inst_word
);
    import cpu_pkg::*;

    localparam int OFS_W    = $clog2(GROUP_WORDS);
    localparam int BASE_MAX = PC_WORDS - GROUP_WORDS;

    word_t              inst_buf [GROUP_WORDS];
    pc_t                group_base;
    pc_t                limited_base;
    logic [11:0]        group_end;
    logic [OFS_W-1:0]   wr_ofs;
    logic [OFS_W-1:0]   rd_ofs;
    logic               beat;

    // keep the whole group inside the word space
    assign limited_base = (pc > pc_t'(BASE_MAX)) ? pc_t'(BASE_MAX) : pc;

    assign beat       = r_valid && r_ready;
    assign group_done = beat && r_last;

    // ============================================================
    // burst request
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_valid   <= 1'b0;
            r_ready    <= 1'b0;
            group_base <= '0;
            wr_ofs     <= '0;
        end else begin
            r_ready <= 1'b1;
            if (fetch_start) begin
                ar_valid   <= 1'b1;
                group_base <= limited_base;
                wr_ofs     <= '0;
            end else begin
                if (ar_valid && ar_ready) begin
                    ar_valid <= 1'b0;
                end
                if (beat) begin
                    wr_ofs <= wr_ofs + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start) begin
            ar_addr <= DRAM_BASE + bus_addr_t'({limited_base, 1'b0});
        end
    end

    // ============================================================
    // instruction buffer
    // ============================================================

    assign rd_ofs = OFS_W'(pc - group_base);

    // beats fill successive offsets, reads are registered
    always_ff @(posedge clk) begin
        if (beat) begin
            inst_buf[wr_ofs] <= r_data;
        end
        inst_word <= inst_buf[rd_ofs];
    end

    assign group_end = {1'b0, group_base} + 12'(GROUP_WORDS);
    assign group_hit = (pc >= group_base) && ({1'b0, pc} < group_end);

endmodule

// File: reg_file.sv
module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t rs_idx,
    input  cpu_pkg::reg_idx_t rt_idx,
    output cpu_pkg::word_t    rs_val,
    output cpu_pkg::word_t    rt_val,
    input  logic              we_alu,
    input  cpu_pkg::reg_idx_t wr_idx,
    input  cpu_pkg::word_t    alu_result,
    input  logic              wb_load,
    input  cpu_pkg::word_t    load_data
);
    import cpu_pkg::*;

    word_t regs [16];

    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];

    // rd for R-type in EX, rt at the retire of a memory access
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we_alu) begin
            regs[wr_idx] <= alu_result;
        end else if (wb_load) begin
            regs[wr_idx] <= load_data;
        end
    end

endmodule

// File: tb_cpu.sv
module tb_cpu;
    import cpu_pkg::*;

    localparam int GROUP_WORDS = 128;
    localparam int MEM_WORDS   = 2048;
    localparam int RUN_LIMIT   = 60000;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      ar_valid;
    bus_addr_t ar_addr;
    logic      ar_ready;
    logic      r_valid;
    word_t     r_data;
    logic      r_last;
    logic      r_ready;
    logic      dr_ar_valid;
    bus_addr_t dr_ar_addr;
    logic      dr_ar_ready;
    logic      dr_r_valid;
    word_t     dr_r_data;
    logic      dr_r_ready;
    logic      aw_valid;
    bus_addr_t aw_addr;
    logic      aw_ready;
    logic      w_valid;
    word_t     w_data;
    logic      w_ready;
    logic      b_valid;
    logic      b_ready;
    logic      io_stall;

    // dram seen by the responder, and the reference model state
    word_t     dram [MEM_WORDS];
    word_t     model_mem [MEM_WORDS];
    word_t     model_regs [16];
    pc_t       model_pc;
    int        model_base;
    logic      done = 1'b0;

    bus_addr_t exp_burst_q [$];
    bus_addr_t st_addr_q [$];
    word_t     st_data_q [$];
    bus_addr_t ld_addr_q [$];

    logic [31:0] seed = 32'hfc1f;
    int        errors = 0;
    int        retired = 0;
    int        pulses = 0;
    int        bursts_seen = 0;
    int        stores_seen = 0;
    int        loads_seen = 0;
    int        beats_total = 0;
    int        cycles;

    // responder state
    logic      ar_go = 1'b0;
    logic      r_go = 1'b0;
    logic      dar_go = 1'b0;
    logic      dr_go = 1'b0;
    logic      aw_go = 1'b0;
    logic      w_go = 1'b0;
    logic      b_go = 1'b0;
    int        ar_cnt = 0;
    int        dar_cnt = 0;
    int        aw_cnt = 0;
    int        w_cnt = 0;
    int        burst_word = 0;
    int        burst_left = 0;
    int        beat_wait = 0;
    logic      rd_pending = 1'b0;
    word_t     rd_word;
    int        rd_wait = 0;
    logic      b_pending = 1'b0;
    int        b_wait = 0;
    bus_addr_t aw_held;
    int        resp_idx;
    logic      stall_low_prev = 1'b0;

    cpu_top #(
        .GROUP_WORDS (GROUP_WORDS),
        .DRAM_BASE   (DRAM_BASE)
    ) dut (.*);

    always #4 clk = ~clk;

    // ============================================================
    // stimulus helpers
    // ============================================================

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {16'h0, seed[31:16]};
    endfunction

    function automatic word_t enc_word(logic [2:0] op, reg_idx_t rs, reg_idx_t rt,
                                       logic [4:0] low);
        return {op, rs, rt, low};
    endfunction

    function automatic word_t enc_jump(pc_t target);
        return {OP_JUMP, 1'b0, target, 1'b0};
    endfunction

    function automatic int addr_to_word(bus_addr_t a);
        if (a < DRAM_BASE || a >= DRAM_BASE + 2 * MEM_WORDS || a[0]) begin
            return -1;
        end
        return (a - DRAM_BASE) >> 1;
    endfunction

    task automatic ready_pace(inout int cnt, output logic rdy);
        if (cnt == 0) begin
            rdy = 1'b1;
            cnt = next_rand() % 4;
        end else begin
            rdy = 1'b0;
            cnt = cnt - 1;
        end
    endtask

    // random body that leaves r0, r14 and r15 untouched
    // r14 keeps the data base
    task automatic gen_body(inout int at, input int n);
        int         pick;
        int         left;
        int         span;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic       func;
        logic [4:0] imm;
        for (int i = 0; i < n; i++) begin
            left = n - 1 - i;
            pick = next_rand() % 10;
            rs   = next_rand() % 16;
            rt   = next_rand() % 16;
            rd   = 1 + next_rand() % 13;
            func = (next_rand() % 2 == 1);
            imm  = next_rand() % 32;
            if (pick < 5) begin
                if (next_rand() % 2 == 0) begin
                    dram[at] = enc_word(OP_ADDSUB, rs, rt, {rd, func});
                end else begin
                    dram[at] = enc_word(OP_SLTMUL, rs, rt, {rd, func});
                end
            end else if (pick < 6) begin
                dram[at] = enc_word(OP_LOAD, 4'd14, rd, imm);
            end else if (pick < 8) begin
                dram[at] = enc_word(OP_STORE, 4'd14, rt, imm);
            end else begin
                // forward skips that never pass the closing jump
                if (next_rand() % 2 == 0) begin
                    rt = rs;
                end
                span = (left < 3) ? left : 3;
                imm  = next_rand() % (span + 1);
                dram[at] = enc_word(OP_BEQ, rs, rt, imm);
            end
            at++;
        end
    endtask

    task automatic build_program();
        int at;
        for (int i = 0; i < MEM_WORDS; i++) begin
            dram[i] = next_rand();
        end
        dram[0] = enc_jump(11'd16);
        // word 1 holds the data region base
        dram[1] = 16'sd1024;
        at = 16;
        dram[at] = enc_word(OP_LOAD, 4'd0, 4'd14, 5'd1);
        at++;
        gen_body(at, 120);
        // target above the last full group base
        dram[at] = enc_jump(11'd1950);
        at = 1950;
        gen_body(at, 70);
        dram[at] = enc_jump(11'd600);
        at = 600;
        gen_body(at, 80);
        for (int k = 0; k < 16; k++) begin
            dram[at] = enc_word(OP_STORE, 4'd14, k, k - 16);
            at++;
        end
        dram[at] = enc_jump(at);
    endtask

    // ============================================================
    // reference model stepped once per io_stall pulse
    // ============================================================

    task automatic model_step();
        word_t             inst;
        word_t             a;
        word_t             b;
        logic [2:0]        op;
        reg_idx_t          rs;
        reg_idx_t          rt;
        reg_idx_t          rd;
        logic signed [4:0] imm;
        int                imm_i;
        int                idx;
        bus_addr_t         addr;
        bus_addr_t         got_addr;
        word_t             got_data;
        logic [31:0]       nxt;
        pc_t               npc;

        inst  = model_mem[model_pc];
        op    = inst[15:13];
        rs    = inst[12:9];
        rt    = inst[8:5];
        rd    = inst[4:1];
        imm   = inst[4:0];
        imm_i = imm;
        a     = model_regs[rs];
        b     = model_regs[rt];
        idx   = a + imm_i;
        addr  = DRAM_BASE + idx * 2;
        npc   = model_pc + 11'd1;
        retired++;

        case (op)
            OP_ADDSUB: model_regs[rd] = inst[0] ? a + b : a - b;
            OP_SLTMUL: begin
                if (inst[0]) begin
                    model_regs[rd] = (a < b) ? 16'sd1 : 16'sd0;
                end else begin
                    model_regs[rd] = a * b;
                end
            end
            OP_STORE: begin
                if (st_addr_q.size() == 0) begin
                    $display("store at pc %0d retired without a write on the bus", model_pc);
                    errors++;
                end else begin
                    got_addr = st_addr_q.pop_front();
                    got_data = st_data_q.pop_front();
                    if (got_addr !== addr) begin
                        $display("[FAIL] aw_addr: got %h expected %h", got_addr, addr);
                        errors++;
                    end
                    if (got_data !== b) begin
                        $display("[FAIL] w_data: got %h expected %h", got_data, b);
                        errors++;
                    end
                end
                if (idx >= 0 && idx < MEM_WORDS) begin
                    model_mem[idx] = b;
                end
            end
            OP_LOAD: begin
                if (ld_addr_q.size() == 0) begin
                    $display("load at pc %0d retired without a read on the bus", model_pc);
                    errors++;
                end else begin
                    got_addr = ld_addr_q.pop_front();
                    if (got_addr !== addr) begin
                        $display("[FAIL] dr_ar_addr: got %h expected %h", got_addr, addr);
                        errors++;
                    end
                end
                if (idx >= 0 && idx < MEM_WORDS) begin
                    model_regs[rt] = model_mem[idx];
                end
            end
            OP_JUMP: begin
                npc = inst[11:1];
                if (npc == model_pc) begin
                    done = 1'b1;
                end
            end
            OP_BEQ: begin
                if (a == b) begin
                    nxt = model_pc + 1 + imm_i;
                    npc = nxt[10:0];
                end
            end
            default: ;
        endcase

        // any access left over belongs to no retired instruction
        if (st_addr_q.size() != 0 || ld_addr_q.size() != 0) begin
            $display("extra data access on the bus before the retire of pc %0d", model_pc);
            errors++;
            st_addr_q.delete();
            st_data_q.delete();
            ld_addr_q.delete();
        end

        if (npc < model_base || npc >= model_base + GROUP_WORDS) begin
            model_base = (npc > MEM_WORDS - GROUP_WORDS) ? MEM_WORDS - GROUP_WORDS : npc;
            exp_burst_q.push_back(DRAM_BASE + model_base * 2);
        end
        model_pc = npc;
    endtask

    // ============================================================
    // dram responder and retire monitor
    // ============================================================

    always @(negedge clk) begin
        // response beats accepted on the last rising edge
        if (r_go) begin
            r_valid = 1'b0;
            r_last  = 1'b0;
        end
        if (dr_go) begin
            dr_r_valid = 1'b0;
        end
        if (b_go) begin
            b_valid = 1'b0;
        end

        if (!io_stall) begin
            pulses++;
            if (stall_low_prev) begin
                $display("io_stall stayed low for more than one cycle");
                errors++;
            end
            if (beats_total < GROUP_WORDS) begin
                $display("io_stall pulsed before the first instruction group arrived");
                errors++;
            end
            if (!done) begin
                model_step();
            end
        end
        stall_low_prev = !io_stall;

        ready_pace(ar_cnt, ar_ready);
        ready_pace(dar_cnt, dr_ar_ready);
        ready_pace(aw_cnt, aw_ready);
        ready_pace(w_cnt, w_ready);

        if (!r_valid && burst_left > 0) begin
            if (beat_wait == 0) begin
                r_valid = 1'b1;
                r_data  = dram[burst_word];
                r_last  = (burst_left == 1);
            end else begin
                beat_wait--;
            end
        end
        if (!dr_r_valid && rd_pending) begin
            if (rd_wait == 0) begin
                dr_r_valid = 1'b1;
                dr_r_data  = rd_word;
                rd_pending = 1'b0;
            end else begin
                rd_wait--;
            end
        end
        if (!b_valid && b_pending) begin
            if (b_wait == 0) begin
                b_valid   = 1'b1;
                b_pending = 1'b0;
            end else begin
                b_wait--;
            end
        end

        // transfers on the coming rising edge
        ar_go  = ar_valid && ar_ready;
        r_go   = r_valid && r_ready;
        dar_go = dr_ar_valid && dr_ar_ready;
        dr_go  = dr_r_valid && dr_r_ready;
        aw_go  = aw_valid && aw_ready;
        w_go   = w_valid && w_ready;
        b_go   = b_valid && b_ready;

        if (ar_go) begin
            bursts_seen++;
            if (exp_burst_q.size() == 0) begin
                $display("group fetch at %h that the model did not predict", ar_addr);
                errors++;
            end else if (exp_burst_q[0] !== ar_addr) begin
                $display("[FAIL] ar_addr: got %h expected %h", ar_addr, exp_burst_q[0]);
                errors++;
                void'(exp_burst_q.pop_front());
            end else begin
                void'(exp_burst_q.pop_front());
            end
            resp_idx = addr_to_word(ar_addr);
            if (resp_idx < 0 || resp_idx > MEM_WORDS - GROUP_WORDS) begin
                $display("group fetch outside the instruction space at %h", ar_addr);
                errors++;
                resp_idx = 0;
            end
            burst_word = resp_idx;
            burst_left = GROUP_WORDS;
            beat_wait  = next_rand() % 4;
        end
        if (r_go) begin
            burst_word++;
            burst_left--;
            beats_total++;
            beat_wait = next_rand() % 4;
        end
        if (dar_go) begin
            loads_seen++;
            ld_addr_q.push_back(dr_ar_addr);
            resp_idx = addr_to_word(dr_ar_addr);
            if (resp_idx < 0) begin
                $display("load address %h lies outside the modeled dram", dr_ar_addr);
                errors++;
                rd_word = '0;
            end else begin
                rd_word = dram[resp_idx];
            end
            rd_pending = 1'b1;
            rd_wait    = next_rand() % 4;
        end
        if (aw_go) begin
            aw_held = aw_addr;
        end
        if (w_go) begin
            stores_seen++;
            st_addr_q.push_back(aw_held);
            st_data_q.push_back(w_data);
            resp_idx = addr_to_word(aw_held);
            if (resp_idx < 0) begin
                $display("store address %h lies outside the modeled dram", aw_held);
                errors++;
            end else begin
                dram[resp_idx] = w_data;
            end
            b_pending = 1'b1;
            b_wait    = next_rand() % 4;
        end
    end

    // ============================================================
    // run control
    // ============================================================

    initial begin
        rst_n       = 1'b0;
        ar_ready    = 1'b0;
        r_valid     = 1'b0;
        r_data      = '0;
        r_last      = 1'b0;
        dr_ar_ready = 1'b0;
        dr_r_valid  = 1'b0;
        dr_r_data   = '0;
        aw_ready    = 1'b0;
        w_ready     = 1'b0;
        b_valid     = 1'b0;

        build_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = dram[i];
        end
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        model_pc   = '0;
        model_base = 0;
        // first group always starts at word 0
        exp_burst_q.push_back(DRAM_BASE);

        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        cycles = 0;
        while (!done && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout: program did not reach its final jump in %0d cycles", RUN_LIMIT);
            errors++;
        end
        if (exp_burst_q.size() != 0) begin
            $display("%0d predicted group fetches never reached the bus", exp_burst_q.size());
            errors++;
        end

        $display("errors=%0d retired=%0d pulses=%0d bursts=%0d stores=%0d loads=%0d",
                 errors, retired, pulses, bursts_seen, stores_seen, loads_seen);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
